//--- filelist.f
uart_cmd_pkg.sv
uart_rx.sv
cmd_assembler.sv
reg_bank.sv
uart_tx.sv
uart_cmd_top.sv
tb_uart_cmd_assertions.sv
tb_uart_cmd.sv

//--- run_sim.sh
#!/bin/sh
# build and run the UART command port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_uart_cmd \
    -o sim_uart_cmd

./obj_dir/sim_uart_cmd

//--- tb_uart_cmd.sv
`timescale 1ns/1ps

module tb_uart_cmd;

    import uart_cmd_pkg::*;

    localparam logic [15:0] BAUD_DIV = 16'd16;   // clk cycles per serial bit
    localparam int          N_RANDOM = 32;       // random commands in the sweep

    // one table row: up to six bytes on rx_line
    typedef struct packed {
        logic            corrupt;   // first byte goes out with a low stop bit
        logic            reply;     // a byte is expected back on tx_line
        logic [2:0]      len;
        logic [5:0][7:0] bytes;     // bytes[0] is sent first
    } row_t;

    logic clk;
    logic rst_n;
    logic rx_line;
    logic tx_line;
    logic [7:0] led;
    logic frame_err;

    row_t        rows[$];
    logic [7:0]  model_regs [REG_COUNT];
    logic [23:0] model_word;                 // mirrors the assembler shift word
    int          model_cnt;
    logic        model_reply;
    logic [7:0]  model_reply_val;
    logic [31:0] rng_state = 32'h5793_5135;
    int          frame_err_cnt;              // pulses seen on frame_err
    int          exp_frame_errs;

    uart_cmd_top #(
        .BAUD_DIV  (BAUD_DIV)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_line   (rx_line),
        .tx_line   (tx_line),
        .led       (led),
        .frame_err (frame_err)
    );

    // ==========================================================================
    // clock, frame error counter, run limit
    // ==========================================================================
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;              // 8 ns period
    end

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            frame_err_cnt <= 0;
        else if (frame_err)
            frame_err_cnt <= frame_err_cnt + 1;
    end

    initial
    begin
        repeat (200000) @(posedge clk);
        $display("simulation ran far too long, some wait never ended");
        $display("CHECKS FAILED");
        $fatal;
    end

    // ==========================================================================
    // helpers
    // ==========================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic row_t make_row(input logic corrupt, input logic reply,
                                      input logic [2:0] len,
                                      input logic [7:0] b0, input logic [7:0] b1,
                                      input logic [7:0] b2, input logic [7:0] b3,
                                      input logic [7:0] b4, input logic [7:0] b5);
        row_t r;
        r.corrupt = corrupt;
        r.reply   = reply;
        r.len     = len;
        r.bytes   = {b5, b4, b3, b2, b1, b0};
        return r;
    endfunction

    // plain three byte command
    function automatic row_t cmd_row(input logic [7:0] op, input logic [7:0] addr,
                                     input logic [7:0] data, input logic reply);
        return make_row(1'b0, reply, 3'd3, op, addr, data, 8'h00, 8'h00, 8'h00);
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("CHECKS FAILED");
            $fatal;
        end
    endtask

    // ==========================================================================
    // reference model, byte level
    // ==========================================================================
    task automatic model_byte(input logic [7:0] b);
        logic [7:0] op;
        logic [7:0] addr;
        logic [7:0] data;
        if (b == RESYNC_BYTE)
        begin
            model_word = '0;                 // partial command thrown away
            model_cnt  = 0;
        end
        else
        begin
            model_word = {model_word[15:0], b};
            model_cnt  = model_cnt + 1;
            if (model_cnt == 3)
            begin
                model_cnt = 0;
                op   = model_word[23:16];
                addr = model_word[15:8];
                data = model_word[7:0];
                if (op == CMD_WRITE && int'(addr) < REG_COUNT)
                    model_regs[addr[3:0]] = data;
                else if (op == CMD_READ)
                begin
                    model_reply     = 1'b1;
                    model_reply_val = (int'(addr) < REG_COUNT) ? model_regs[addr[3:0]]
                                                               : 8'h00;
                end
            end
        end
    endtask

    task automatic model_row(input row_t r);
        model_reply = 1'b0;
        for (int i = 0; i < int'(r.len); i++)
        begin
            if (!(r.corrupt && i == 0))     // bad frame never reaches the assembler
                model_byte(r.bytes[i]);
        end
    endtask

    // ==========================================================================
    // serial driver and reply monitor
    // ==========================================================================
    task automatic send_serial(input logic [7:0] b, input logic bad_stop);
        logic [9:0] frame;
        frame = {~bad_stop, b, 1'b0};       // stop, data lsb first, start
        for (int i = 0; i < 10; i++)
        begin
            rx_line <= frame[i];
            repeat (BAUD_DIV) @(posedge clk);
        end
        rx_line <= 1'b1;                    // one idle bit between bytes
        repeat (BAUD_DIV) @(posedge clk);
    endtask

    task automatic drive_row(input row_t r);
        for (int i = 0; i < int'(r.len); i++)
            send_serial(r.bytes[i], r.corrupt && i == 0);
    endtask

    task automatic watch_tx(input int limit, output logic got, output logic [7:0] val);
        int n;
        n   = 0;
        got = 1'b0;
        val = 8'h00;
        while (tx_line !== 1'b0 && n < limit)   // look for a start bit
        begin
            @(posedge clk);
            n++;
        end
        if (tx_line === 1'b0)
        begin
            got = 1'b1;
            repeat (BAUD_DIV / 2) @(posedge clk);
            check("tx_line start bit", 32'(tx_line), 32'h0);
            for (int i = 0; i < 8; i++)
            begin
                repeat (BAUD_DIV) @(posedge clk);
                val[i] = tx_line;           // middle of data bit i
            end
            repeat (BAUD_DIV) @(posedge clk);
            check("tx_line stop bit", 32'(tx_line), 32'h1);
        end
    endtask

    // ==========================================================================
    // one row: drive, watch, compare against the model
    // ==========================================================================
    task automatic run_row(input row_t r);
        logic       got;
        logic [7:0] val;
        int         limit;
        model_row(r);
        check("reply expected", 32'(r.reply), 32'(model_reply));
        if (r.corrupt)
            exp_frame_errs++;
        limit = (int'(r.len) * 11 + 8) * int'(BAUD_DIV);
        fork
            drive_row(r);
            watch_tx(limit, got, val);
        join
        if (r.reply && !got)
        begin
            $display("timeout, no reply start bit on tx_line within %0d cycles", limit);
            $display("CHECKS FAILED");
            $fatal;
        end
        else
        begin
            check("reply seen", 32'(got), 32'(r.reply));
            if (got)
                check("reply_byte", 32'(val), 32'(model_reply_val));
            check("led", 32'(led), 32'(model_regs[0]));
            check("frame_err count", 32'(frame_err_cnt), 32'(exp_frame_errs));
        end
    endtask

    task automatic build_table();
        logic [7:0] addr;
        logic [7:0] data;
        // write then read, led through register 0
        rows.push_back(cmd_row(8'h01, 8'h00, 8'h5A, 1'b0));
        rows.push_back(cmd_row(8'h02, 8'h00, 8'h00, 1'b1));
        rows.push_back(cmd_row(8'h01, 8'h03, 8'hC3, 1'b0));
        rows.push_back(cmd_row(8'h02, 8'h03, 8'h00, 1'b1));
        rows.push_back(cmd_row(8'h01, 8'h0F, 8'h81, 1'b0));
        rows.push_back(cmd_row(8'h02, 8'h0F, 8'h00, 1'b1));
        rows.push_back(cmd_row(8'h01, 8'h07, 8'h3C, 1'b0));
        rows.push_back(cmd_row(8'h02, 8'h07, 8'h00, 1'b1));
        rows.push_back(cmd_row(8'h01, 8'h00, 8'hA5, 1'b0));
        rows.push_back(cmd_row(8'h02, 8'h00, 8'h00, 1'b1));
        // partial commands cut by the resync marker
        rows.push_back(make_row(1'b0, 1'b1, 3'd5, 8'h02, 8'hFF, 8'h02, 8'h03, 8'h00, 8'h00));
        rows.push_back(make_row(1'b0, 1'b1, 3'd6, 8'h01, 8'h07, 8'hFF, 8'h02, 8'h07, 8'h00));
        // bad stop bit on the first byte, rest reads as READ 3
        rows.push_back(make_row(1'b1, 1'b1, 3'd4, 8'h01, 8'h02, 8'h03, 8'h00, 8'h00, 8'h00));
        rows.push_back(cmd_row(8'h01, 8'h03, 8'h99, 1'b0));
        rows.push_back(cmd_row(8'h02, 8'h03, 8'h00, 1'b1));
        // unknown opcode and out of range address
        rows.push_back(cmd_row(8'h07, 8'h03, 8'h11, 1'b0));
        rows.push_back(cmd_row(8'h02, 8'h03, 8'h00, 1'b1));
        rows.push_back(cmd_row(8'h01, 8'h20, 8'h55, 1'b0));
        rows.push_back(cmd_row(8'h02, 8'h20, 8'h00, 1'b1));
        rows.push_back(cmd_row(8'h02, 8'h00, 8'h00, 1'b1));
        // random sweep
        for (int i = 0; i < N_RANDOM; i++)
        begin
            rng_state = xorshift32(rng_state);
            addr = {4'h0, rng_state[3:0]};
            data = rng_state[15:8];
            if (data == 8'hFF)
                data = 8'h00;               // 0xFF is the resync marker
            if (rng_state[20])
                rows.push_back(cmd_row(8'h01, addr, data, 1'b0));
            else
                rows.push_back(cmd_row(8'h02, addr, 8'h00, 1'b1));
        end
    endtask

    // ==========================================================================
    // main sequence
    // ==========================================================================
    initial
    begin
        rst_n          = 1'b0;
        rx_line        = 1'b1;              // line idles high
        model_word     = '0;
        model_cnt      = 0;
        model_reply    = 1'b0;
        exp_frame_errs = 0;
        for (int i = 0; i < REG_COUNT; i++)
            model_regs[i] = 8'h00;
        build_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        check("led after reset", 32'(led), 32'h0);
        check("tx_line after reset", 32'(tx_line), 32'h1);
        for (int i = 0; i < rows.size(); i++)
            run_row(rows[i]);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- tb_uart_cmd_assertions.sv
`timescale 1ns/1ps

module tb_uart_cmd_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic       byte_valid,
    input logic       cmd_valid,
    input logic       reply_start,
    input logic       tx_busy,
    input logic       tx_line,
    input logic [7:0] led
);

    // ==========================================================================
    // strobes are single cycle
    // ==========================================================================
    a_byte_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        byte_valid |=> !byte_valid) else $error("byte_valid high two cycles in a row");

    a_cmd_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid |=> !cmd_valid) else $error("cmd_valid high two cycles in a row");

    a_reply_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        reply_start |=> !reply_start) else $error("reply_start high two cycles in a row");

    // no back-pressure, a reply must find the transmitter idle
    a_reply_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        reply_start |-> !tx_busy) else $error("reply_start while transmitter busy");

    a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> tx_line) else $error("tx_line low while transmitter idle");

    a_led_reset: assert property (@(posedge clk)
        !rst_n |-> led == 8'h00) else $error("led not zero during reset");

endmodule

bind uart_cmd_top tb_uart_cmd_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .byte_valid  (byte_valid),
    .cmd_valid   (cmd_valid),
    .reply_start (reply_start),
    .tx_busy     (tx_busy),
    .tx_line     (tx_line),
    .led         (led)
);

//--- uart_cmd_top.sv
`timescale 1ns/1ps

module uart_cmd_top #(
    parameter logic [15:0] BAUD_DIV = 16'd16   // clk cycles per bit
)
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx_line,                  // command stream in
    output logic       tx_line,                  // read replies out
    output logic [7:0] led,                      // mirror of register 0
    output logic       frame_err                 // pulse per bad stop bit
);

    import uart_cmd_pkg::*;

    // ========================================================================
    // internal strobes and data
    // ========================================================================
    logic [7:0] rx_byte;
    logic       byte_valid;
    cmd_t       cmd;
    logic       cmd_valid;
    logic [7:0] reply_byte;
    logic       reply_start;
    logic       tx_busy;        // transmitter level, no consumer in the datapath

    uart_rx #(
        .BAUD_DIV   (BAUD_DIV)
    ) u_uart_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_line    (rx_line),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid),
        .frame_err  (frame_err)
    );

    cmd_assembler u_cmd_assembler (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_byte    (rx_byte),
        .byte_valid (byte_valid),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid)
    );

    reg_bank u_reg_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .led         (led),
        .reply_byte  (reply_byte),
        .reply_start (reply_start)
    );

    // replies are 10 bit times, commands 30, so never busy on a new reply
    uart_tx #(
        .BAUD_DIV    (BAUD_DIV)
    ) u_uart_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .reply_byte  (reply_byte),
        .reply_start (reply_start),
        .tx_line     (tx_line),
        .tx_busy     (tx_busy)
    );

endmodule

//--- uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter logic [15:0] BAUD_DIV = 16'd16   // clk cycles per bit, 4 or more
)
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] reply_byte,
    input  logic       reply_start,             // one-cycle request
    output logic       tx_line,                 // idles high
    output logic       tx_busy
);

    import uart_cmd_pkg::*;

    localparam logic [15:0] LAST_CNT = BAUD_DIV - 16'd1;

    tx_state_e   state;
    logic [15:0] baud_cnt;
    logic [2:0]  bit_cnt;       // data bit now on the line
    logic [7:0]  shift_reg;     // bit 0 is next to send
    logic        end_bit;
    logic        load;

    assign end_bit = (baud_cnt == LAST_CNT);
    assign load    = reply_start && (state == TX_IDLE);     // dropped when busy
    assign tx_busy = (state != TX_IDLE);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            baud_cnt <= '0;
        else if (state == TX_IDLE || end_bit)
            baud_cnt <= '0;
        else
            baud_cnt <= baud_cnt + 16'd1;
    end

    // ========================================================================
    // frame FSM, drives the line from a register
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            tx_line <= 1'b1;
        end
        else
        begin
            case (state)
                TX_IDLE:
                    if (load)
                    begin
                        state   <= TX_START;
                        tx_line <= 1'b0;            // start bit next cycle
                    end
                TX_START:
                    if (end_bit)
                    begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                        tx_line <= shift_reg[0];    // lsb first
                    end
                TX_DATA:
                    if (end_bit)
                    begin
                        if (bit_cnt == 3'd7)
                        begin
                            state   <= TX_STOP;
                            tx_line <= 1'b1;        // stop bit
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            tx_line <= shift_reg[1];  // bit about to shift down
                        end
                    end
                TX_STOP:
                    if (end_bit)
                        state <= TX_IDLE;           // line already high
                default:
                begin
                    state   <= TX_IDLE;
                    tx_line <= 1'b1;
                end
            endcase
        end
    end

    // byte holder
    always_ff @(posedge clk)
    begin
        if (load)
            shift_reg <= reply_byte;
        else if (state == TX_DATA && end_bit)
            shift_reg <= {1'b0, shift_reg[7:1]};
    end

endmodule

//--- reg_bank.sv
`timescale 1ns/1ps

module reg_bank (
    input  logic               clk,
    input  logic               rst_n,
    input  uart_cmd_pkg::cmd_t cmd,
    input  logic               cmd_valid,
    output logic [7:0]         led,
    output logic [7:0]         reply_byte,
    output logic               reply_start
);

    import uart_cmd_pkg::*;

    localparam int IDX_W = $clog2(REG_COUNT);

    logic [7:0]       regs [REG_COUNT];
    logic [IDX_W-1:0] idx;
    logic             addr_ok;      // addr inside the bank
    logic             do_write;
    logic             do_read;

    assign idx     = cmd.addr[IDX_W-1:0];
    assign addr_ok = (cmd.addr < 8'(REG_COUNT));

    // ========================================================================
    // opcode decode
    // ========================================================================
    always_comb
    begin
        do_write = 1'b0;
        do_read  = 1'b0;
        if (cmd_valid)
        begin
            case (cmd.op)
                CMD_WRITE:
                    do_write = addr_ok;     // out of range writes vanish
                CMD_READ:
                    do_read = 1'b1;         // always answered, maybe with 0x00
                default:
                begin
                    do_write = 1'b0;        // unknown opcode
                    do_read  = 1'b0;
                end
            endcase
        end
    end

    // ========================================================================
    // register storage
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < REG_COUNT; i++)
            begin
                regs[i] <= 8'h00;
            end
        end
        else if (do_write)
        begin
            regs[idx] <= cmd.data;
        end
    end

    assign led = regs[0];           // register 0 drives the leds

    // read reply, start strobe and byte in the same cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            reply_start <= 1'b0;
        else
            reply_start <= do_read;
    end

    always_ff @(posedge clk)
    begin
        if (do_read)
            reply_byte <= addr_ok ? regs[idx] : 8'h00;
    end

endmodule

//--- cmd_assembler.sv
`timescale 1ns/1ps

module cmd_assembler (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [7:0]         rx_byte,
    input  logic               byte_valid,     // one-cycle strobe from uart_rx
    output uart_cmd_pkg::cmd_t cmd,
    output logic               cmd_valid       // one cycle per full command
);

    import uart_cmd_pkg::*;

    logic [23:0] cmd_word;      // op in the top byte once three bytes are in
    logic [1:0]  byte_cnt;      // bytes taken since last command or resync
    logic        is_resync;
    logic        last_byte;

    assign is_resync = (rx_byte == RESYNC_BYTE);
    assign last_byte = (byte_cnt == 2'd2);

    // ========================================================================
    // byte collection
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cmd_word  <= '0;
            byte_cnt  <= '0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;                  // strobe by default
            if (byte_valid)
            begin
                if (is_resync)
                begin
                    // marker byte, drop whatever was collected
                    cmd_word <= '0;
                    byte_cnt <= '0;
                end
                else
                begin
                    cmd_word <= {cmd_word[15:0], rx_byte};
                    if (last_byte)
                    begin
                        byte_cnt  <= '0;
                        cmd_valid <= 1'b1;      // word is complete next cycle
                    end
                    else
                    begin
                        byte_cnt <= byte_cnt + 2'd1;
                    end
                end
            end
        end
    end

    // word register read as op, addr, data
    assign cmd = cmd_t'(cmd_word);

endmodule

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter logic [15:0] BAUD_DIV = 16'd16   // clk cycles per bit, 4 or more
)
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx_line,                  // async serial in, idles high
    output logic [7:0] rx_byte,
    output logic       byte_valid,
    output logic       frame_err
);

    import uart_cmd_pkg::*;

    localparam logic [15:0] HALF_CNT = BAUD_DIV >> 1;       // mid-bit sample point
    localparam logic [15:0] LAST_CNT = BAUD_DIV - 16'd1;    // last cycle of a bit

    rx_state_e   state;
    rx_state_e   state_nxt;
    logic        rx_meta;       // first sync stage
    logic        rx_sync;       // safe copy of rx_line
    logic        rx_prev;       // one cycle older, for edge detect
    logic        fall;
    logic [15:0] baud_cnt;
    logic [2:0]  bit_cnt;       // data bit index
    logic        mid_bit;
    logic        end_bit;

    // ========================================================================
    // input synchronizer and edge detect
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rx_meta <= 1'b1;    // idle level
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall    = rx_prev & ~rx_sync;            // high to low on the line
    assign mid_bit = (baud_cnt == HALF_CNT);
    assign end_bit = (baud_cnt == LAST_CNT);

    // bit timing, held at zero between frames
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            baud_cnt <= '0;
        else if (state == RX_IDLE || state == RX_DONE || end_bit)
            baud_cnt <= '0;
        else
            baud_cnt <= baud_cnt + 16'd1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            bit_cnt <= '0;
        else if (state == RX_IDLE)
            bit_cnt <= '0;
        else if (state == RX_DATA && end_bit)
            bit_cnt <= bit_cnt + 3'd1;      // wraps to 0 after bit 7
    end

    // ========================================================================
    // frame FSM
    // ========================================================================
    always_comb
    begin
        state_nxt = state;
        case (state)
            RX_IDLE:
                if (fall)
                    state_nxt = RX_START;
            RX_START:
            begin
                if (mid_bit && rx_sync)
                    state_nxt = RX_IDLE;    // line back high so only a glitch
                else if (end_bit)
                    state_nxt = RX_DATA;
            end
            RX_DATA:
                if (end_bit && bit_cnt == 3'd7)
                    state_nxt = RX_STOP;
            RX_STOP:
                if (mid_bit)
                    state_nxt = RX_DONE;    // no need to wait out the stop bit
            RX_DONE:
                state_nxt = rx_sync ? RX_IDLE : RX_START;
            default:
                state_nxt = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= RX_IDLE;
        else
            state <= state_nxt;
    end

    // stop bit check, one strobe or the other
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end
        else
        begin
            byte_valid <= (state == RX_STOP) && mid_bit && rx_sync;
            frame_err  <= (state == RX_STOP) && mid_bit && !rx_sync;
        end
    end

    // data shifter, lsb arrives first and ends up in bit 0
    always_ff @(posedge clk)
    begin
        if (state == RX_DATA && mid_bit)
            rx_byte <= {rx_sync, rx_byte[7:1]};
    end

endmodule

//--- uart_cmd_pkg.sv
package uart_cmd_pkg;

    // ========================================================================
    // command encoding
    // ========================================================================

    // opcode byte, first byte of every command
    typedef enum logic [7:0] {
        CMD_WRITE = 8'h01,      // store data byte at addr
        CMD_READ  = 8'h02       // send addressed register back on tx_line
    } cmd_op_e;                 // any other value is a no-op

    // three bytes as they arrive, oldest in the top bits
    typedef struct packed {
        cmd_op_e    op;         // byte 0
        logic [7:0] addr;       // byte 1, 16 and up is out of range
        logic [7:0] data;       // byte 2, don't care on read
    } cmd_t;

    // ========================================================================
    // serial FSM states
    // ========================================================================

    typedef enum logic [2:0] {
        RX_IDLE  = 3'd0,        // waiting for falling edge
        RX_START = 3'd1,        // inside start bit
        RX_DATA  = 3'd2,        // 8 data bits, lsb first
        RX_STOP  = 3'd3,        // up to stop bit mid-sample
        RX_DONE  = 3'd4         // one cycle, strobes go out
    } rx_state_e;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,        // line high
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

    // ========================================================================
    // constants
    // ========================================================================

    // clears a partly assembled command, never a payload byte
    localparam logic [7:0] RESYNC_BYTE = 8'hFF;

    // registers in the bank
    localparam int REG_COUNT = 16;

endpackage
